/* rtl/lsu_pkg.sv */
// shared types, operation and width codes and memory depth for the load/store stage
`default_nettype none

package lsu_pkg;

    // data and address words
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // one strobe bit per byte lane
    typedef logic [3:0] strb_t;

    // rv32e has 16 registers
    typedef logic [3:0] reg_addr_t;

    // memory operation codes
    typedef logic [1:0] mem_op_t;
    localparam mem_op_t OP_NONE  = 2'd0;
    localparam mem_op_t OP_READ  = 2'd1;
    localparam mem_op_t OP_WRITE = 2'd2;

    // access widths, stores treat signed and unsigned codes alike
    typedef logic [2:0] mem_width_t;
    localparam mem_width_t W_BYTE   = 3'd0;
    localparam mem_width_t W_BYTE_U = 3'd1;
    localparam mem_width_t W_HALF   = 3'd2;
    localparam mem_width_t W_HALF_U = 3'd3;
    localparam mem_width_t W_WORD   = 3'd4;

    // memory depth in words
    localparam int MEM_WORDS = 256;

    // stage FSM, bit 0 clear means ready for upstream, bit 1 set means sending
    typedef enum logic [1:0] {
        S_IDLE   = 2'b00,
        S_ACCESS = 2'b01,
        S_SEND   = 2'b11
    } stage_state_t;

endpackage

`default_nettype wire

/* rtl/store_lane_gen.sv */
// combinational store lane placement, gives byte strobes and shifted write data
`default_nettype none
`timescale 1ns/1ns

module store_lane_gen (
    input  wire lsu_pkg::mem_width_t width,
    input  wire logic [1:0]          offset,
    input  wire lsu_pkg::word_t      data,
    output lsu_pkg::strb_t           strb,
    output lsu_pkg::word_t           lane_data
);

    // byte offset turned into a bit shift
    logic [4:0] shamt;

    assign shamt = {offset, 3'b000};

    // each stored byte lands in its own lane
    assign lane_data = data << shamt;

    always_comb begin
        case (width)
            lsu_pkg::W_BYTE, lsu_pkg::W_BYTE_U: begin
                strb = 4'b0001 << offset;
            end
            lsu_pkg::W_HALF, lsu_pkg::W_HALF_U: begin
                // halfword crossing the word boundary writes nothing
                if (offset == 2'd3) begin
                    strb = 4'b0000;
                end else begin
                    strb = 4'b0011 << offset;
                end
            end
            lsu_pkg::W_WORD: begin
                // only aligned words write
                if (offset == 2'd0) begin
                    strb = 4'b1111;
                end else begin
                    strb = 4'b0000;
                end
            end
            default: begin
                strb = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/load_align.sv */
// combinational load alignment, shifts the read word and extends it for the load width
`default_nettype none
`timescale 1ns/1ns

module load_align (
    input  wire lsu_pkg::mem_width_t width,
    input  wire logic [1:0]          offset,
    input  wire lsu_pkg::word_t      raw,
    output lsu_pkg::word_t           value
);

    logic [4:0]     shamt;
    lsu_pkg::word_t shifted;
    logic [7:0]     r_byte;
    logic [15:0]    r_half;

    assign shamt   = {offset, 3'b000};
    assign shifted = raw >> shamt;
    assign r_byte  = shifted[7:0];

    // halfword at offset 3 would straddle two words, reads as zero
    assign r_half = (offset == 2'd3) ? 16'h0000 : shifted[15:0];

    always_comb begin
        case (width)
            lsu_pkg::W_BYTE: begin
                value = {{24{r_byte[7]}}, r_byte};
            end
            lsu_pkg::W_BYTE_U: begin
                value = {24'h000000, r_byte};
            end
            lsu_pkg::W_HALF: begin
                value = {{16{r_half[15]}}, r_half};
            end
            lsu_pkg::W_HALF_U: begin
                value = {16'h0000, r_half};
            end
            default: begin
                // word loads return the aligned word as read
                value = raw;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
// load/store pipeline stage, runs one access at a time over an AXI-Lite master port
`default_nettype none
`timescale 1ns/1ns

module mem_stage (
    input  wire                      clk,
    input  wire                      reset,

    // upstream from execute
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire lsu_pkg::mem_op_t    in_op,
    input  wire lsu_pkg::mem_width_t in_width,
    input  wire lsu_pkg::addr_t      in_addr,
    input  wire lsu_pkg::word_t      in_store_data,
    input  wire lsu_pkg::word_t      in_result,
    input  wire lsu_pkg::reg_addr_t  in_rd_addr,
    input  wire                      in_rd_write,
    input  wire                      in_rd_from_mem,

    // downstream to writeback
    output logic                     out_valid,
    input  wire                      out_ready,
    output lsu_pkg::reg_addr_t       wb_rd_addr,
    output logic                     wb_rd_write,
    output lsu_pkg::word_t           wb_data,

    // to the hazard unit
    output logic                     load_pending,

    // AXI-Lite master
    output lsu_pkg::addr_t           araddr,
    output logic                     arvalid,
    input  wire                      arready,
    input  wire lsu_pkg::word_t      rdata,
    input  wire                      rvalid,
    output logic                     rready,
    output lsu_pkg::addr_t           awaddr,
    output logic                     awvalid,
    input  wire                      awready,
    output lsu_pkg::word_t           wdata,
    output lsu_pkg::strb_t           wstrb,
    output logic                     wvalid,
    input  wire                      wready,
    input  wire                      bvalid,
    output logic                     bready
);

    lsu_pkg::stage_state_t state;

    // instruction held between the two handshakes
    lsu_pkg::mem_op_t    op_q;
    lsu_pkg::mem_width_t width_q;
    logic [1:0]          offset_q;
    lsu_pkg::word_t      result_q;
    lsu_pkg::reg_addr_t  rd_addr_q;
    logic                rd_write_q;
    logic                rd_from_mem_q;
    lsu_pkg::word_t      rdata_q;

    lsu_pkg::strb_t      lane_strb;
    lsu_pkg::word_t      lane_data;
    lsu_pkg::word_t      load_value;

    logic                accept;
    logic                aw_left;
    logic                w_left;

    assign in_ready  = (state == lsu_pkg::S_IDLE);
    assign out_valid = (state == lsu_pkg::S_SEND);
    assign accept    = in_valid && in_ready;

    // write channels still waiting after this edge
    assign aw_left = awvalid && !awready;
    assign w_left  = wvalid && !wready;

    store_lane_gen u_store_lane_gen (
        .width     (in_width),
        .offset    (in_addr[1:0]),
        .data      (in_store_data),
        .strb      (lane_strb),
        .lane_data (lane_data)
    );

    load_align u_load_align (
        .width  (width_q),
        .offset (offset_q),
        .raw    (rdata_q),
        .value  (load_value)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= lsu_pkg::S_IDLE;
            arvalid      <= 1'b0;
            awvalid      <= 1'b0;
            wvalid       <= 1'b0;
            rready       <= 1'b0;
            bready       <= 1'b0;
            load_pending <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::S_IDLE: begin
                    if (accept) begin
                        // bus request goes out on the accepting edge
                        if (in_op == lsu_pkg::OP_READ) begin
                            arvalid      <= 1'b1;
                            load_pending <= 1'b1;
                            state        <= lsu_pkg::S_ACCESS;
                        end else if (in_op == lsu_pkg::OP_WRITE) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= lsu_pkg::S_ACCESS;
                        end else begin
                            state <= lsu_pkg::S_SEND;
                        end
                    end
                end
                lsu_pkg::S_ACCESS: begin
                    if (op_q == lsu_pkg::OP_READ) begin
                        if (arvalid && arready) begin
                            arvalid <= 1'b0;
                            rready  <= 1'b1;
                        end
                        if (rvalid && rready) begin
                            rready       <= 1'b0;
                            load_pending <= 1'b0;
                            state        <= lsu_pkg::S_SEND;
                        end
                    end else begin
                        if (awready) begin
                            awvalid <= 1'b0;
                        end
                        if (wready) begin
                            wvalid <= 1'b0;
                        end
                        // wait for the response once address and data are taken
                        if (bvalid && bready) begin
                            bready <= 1'b0;
                            state  <= lsu_pkg::S_SEND;
                        end else if (!aw_left && !w_left) begin
                            bready <= 1'b1;
                        end
                    end
                end
                lsu_pkg::S_SEND: begin
                    if (out_ready) begin
                        state <= lsu_pkg::S_IDLE;
                    end
                end
                default: begin
                    state <= lsu_pkg::S_IDLE;
                end
            endcase
        end
    end

    // sideband and bus payload
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q          <= in_op;
            width_q       <= in_width;
            offset_q      <= in_addr[1:0];
            result_q      <= in_result;
            rd_addr_q     <= in_rd_addr;
            rd_write_q    <= in_rd_write;
            rd_from_mem_q <= in_rd_from_mem;
            araddr        <= in_addr;
            awaddr        <= in_addr;
            wdata         <= lane_data;
            wstrb         <= lane_strb;
        end
        if (rvalid && rready) begin
            rdata_q <= rdata;
        end
    end

    assign wb_rd_addr  = rd_addr_q;
    assign wb_rd_write = rd_write_q;
    assign wb_data     = rd_from_mem_q ? load_value : result_q;

endmodule

`default_nettype wire

/* rtl/axi_sram.sv */
// word-wide AXI-Lite slave memory with byte-strobe writes, answers one cycle after each address
`default_nettype none
`timescale 1ns/1ns

module axi_sram (
    input  wire                 clk,
    input  wire                 reset,

    // read channels
    input  wire lsu_pkg::addr_t araddr,
    input  wire                 arvalid,
    output logic                arready,
    output lsu_pkg::word_t      rdata,
    output logic                rvalid,
    input  wire                 rready,

    // write channels
    input  wire lsu_pkg::addr_t awaddr,
    input  wire                 awvalid,
    output logic                awready,
    input  wire lsu_pkg::word_t wdata,
    input  wire lsu_pkg::strb_t wstrb,
    input  wire                 wvalid,
    output logic                wready,
    output logic                bvalid,
    input  wire                 bready
);

    lsu_pkg::word_t mem [lsu_pkg::MEM_WORDS];

    // awready and wready always rise together
    logic wr_accept;
    logic rd_fire;
    logic wr_fire;

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign rd_fire = arvalid && arready;
    assign wr_fire = awvalid && awready && wvalid && wready;

    always_ff @(posedge clk) begin
        if (reset) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            wr_accept <= 1'b0;
            bvalid    <= 1'b0;
        end else begin
            // one-cycle ready pulse when idle
            arready   <= arvalid && !arready && !rvalid;
            wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;

            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end

            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // array and read data, higher address bits are ignored
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= mem[araddr[$clog2(lsu_pkg::MEM_WORDS)+1:2]];
        end
        if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[awaddr[$clog2(lsu_pkg::MEM_WORDS)+1:2]][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
// top of the load/store unit, joins the stage to its AXI-Lite memory
`default_nettype none
`timescale 1ns/1ns

module lsu_top (
    input  wire                      clk,
    input  wire                      reset,

    // upstream from execute
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire lsu_pkg::mem_op_t    in_op,
    input  wire lsu_pkg::mem_width_t in_width,
    input  wire lsu_pkg::addr_t      in_addr,
    input  wire lsu_pkg::word_t      in_store_data,
    input  wire lsu_pkg::word_t      in_result,
    input  wire lsu_pkg::reg_addr_t  in_rd_addr,
    input  wire                      in_rd_write,
    input  wire                      in_rd_from_mem,

    // downstream to writeback
    output logic                     out_valid,
    input  wire                      out_ready,
    output lsu_pkg::reg_addr_t       wb_rd_addr,
    output logic                     wb_rd_write,
    output lsu_pkg::word_t           wb_data,

    output logic                     load_pending
);

    // internal AXI-Lite bus
    wire lsu_pkg::addr_t araddr;
    wire                 arvalid;
    wire                 arready;
    wire lsu_pkg::word_t rdata;
    wire                 rvalid;
    wire                 rready;
    wire lsu_pkg::addr_t awaddr;
    wire                 awvalid;
    wire                 awready;
    wire lsu_pkg::word_t wdata;
    wire lsu_pkg::strb_t wstrb;
    wire                 wvalid;
    wire                 wready;
    wire                 bvalid;
    wire                 bready;

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_op          (in_op),
        .in_width       (in_width),
        .in_addr        (in_addr),
        .in_store_data  (in_store_data),
        .in_result      (in_result),
        .in_rd_addr     (in_rd_addr),
        .in_rd_write    (in_rd_write),
        .in_rd_from_mem (in_rd_from_mem),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .wb_rd_addr     (wb_rd_addr),
        .wb_rd_write    (wb_rd_write),
        .wb_data        (wb_data),
        .load_pending   (load_pending),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rvalid         (rvalid),
        .rready         (rready),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wvalid         (wvalid),
        .wready         (wready),
        .bvalid         (bvalid),
        .bready         (bready)
    );

    axi_sram u_axi_sram (
        .clk     (clk),
        .reset   (reset),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

`default_nettype wire

/* bench/lsu_tb.sv */
// testbench for lsu_top that replays the trace file under random out_ready back-pressure
`default_nettype none
`timescale 1ns/1ns

module lsu_tb;

    logic                clk;
    logic                reset;
    logic                in_valid;
    logic                in_ready;
    lsu_pkg::mem_op_t    in_op;
    lsu_pkg::mem_width_t in_width;
    lsu_pkg::addr_t      in_addr;
    lsu_pkg::word_t      in_store_data;
    lsu_pkg::word_t      in_result;
    lsu_pkg::reg_addr_t  in_rd_addr;
    logic                in_rd_write;
    logic                in_rd_from_mem;
    logic                out_valid;
    logic                out_ready;
    lsu_pkg::reg_addr_t  wb_rd_addr;
    logic                wb_rd_write;
    lsu_pkg::word_t      wb_data;
    logic                load_pending;

    // trace columns with one entry per instruction
    lsu_pkg::mem_op_t    tr_op[$];
    lsu_pkg::mem_width_t tr_width[$];
    lsu_pkg::addr_t      tr_addr[$];
    lsu_pkg::word_t      tr_store_data[$];
    lsu_pkg::word_t      tr_result[$];
    lsu_pkg::reg_addr_t  tr_rd_addr[$];
    logic                tr_rd_write[$];
    logic                tr_rd_from_mem[$];
    lsu_pkg::word_t      tr_wb_data[$];
    logic                tr_pend[$];

    int          trace_len    = 0;
    logic        trace_loaded = 1'b0;
    int          error_count  = 0;
    int          check_count  = 0;
    int          check_idx    = 0;
    int          accept_idx   = 0;
    logic        busy         = 1'b0;
    logic        cur_pend     = 1'b0;
    logic [31:0] lfsr_state   = 32'h6e46cf94;

    lsu_top uut (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_op          (in_op),
        .in_width       (in_width),
        .in_addr        (in_addr),
        .in_store_data  (in_store_data),
        .in_result      (in_result),
        .in_rd_addr     (in_rd_addr),
        .in_rd_write    (in_rd_write),
        .in_rd_from_mem (in_rd_from_mem),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .wb_rd_addr     (wb_rd_addr),
        .wb_rd_write    (wb_rd_write),
        .wb_data        (wb_data),
        .load_pending   (load_pending)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_counts();
        $display("checks: %0d, errors: %0d, writebacks: %0d of %0d",
                 check_count, error_count, check_idx, trace_len);
    endtask

    task automatic load_trace();
        int               fd;
        int               code;
        logic [8*128-1:0] rest;
        logic [31:0] f_op, f_width, f_addr, f_sd, f_res;
        logic [31:0] f_rd, f_rw, f_rfm, f_wb, f_pend;
        fd = $fopen("bench/lsu_trace.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open the trace file bench/lsu_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h\n", f_op, f_width, f_addr,
                               f_sd, f_res, f_rd, f_rw, f_rfm, f_wb, f_pend);
                if (code == 10) begin
                    tr_op.push_back(f_op[1:0]);
                    tr_width.push_back(f_width[2:0]);
                    tr_addr.push_back(f_addr);
                    tr_store_data.push_back(f_sd);
                    tr_result.push_back(f_res);
                    tr_rd_addr.push_back(f_rd[3:0]);
                    tr_rd_write.push_back(f_rw[0]);
                    tr_rd_from_mem.push_back(f_rfm[0]);
                    tr_wb_data.push_back(f_wb);
                    tr_pend.push_back(f_pend[0]);
                end else begin
                    if (code > 0) begin
                        error_count++;
                        $display("trace line %0d has only %0d fields", tr_op.size() + 1, code);
                    end
                    // comment lines and leftovers
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
        trace_len = tr_op.size();
        if (trace_len == 0) begin
            error_count++;
            $display("the trace holds no instructions");
        end
    endtask

    task automatic present_line(input int idx);
        in_valid       <= 1'b1;
        in_op          <= tr_op[idx];
        in_width       <= tr_width[idx];
        in_addr        <= tr_addr[idx];
        in_store_data  <= tr_store_data[idx];
        in_result      <= tr_result[idx];
        in_rd_addr     <= tr_rd_addr[idx];
        in_rd_write    <= tr_rd_write[idx];
        in_rd_from_mem <= tr_rd_from_mem[idx];
    endtask

    initial begin : stimulus
        int issue_idx;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_op          = lsu_pkg::OP_NONE;
        in_width       = lsu_pkg::W_WORD;
        in_addr        = '0;
        in_store_data  = '0;
        in_result      = '0;
        in_rd_addr     = '0;
        in_rd_write    = 1'b0;
        in_rd_from_mem = 1'b0;
        out_ready      = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (issue_idx = 0; issue_idx < trace_len; issue_idx++) begin
            present_line(issue_idx);
            // hold the line until the stage takes it
            do begin
                @(posedge clk);
            end while (!in_ready);
        end
        in_valid <= 1'b0;
        wait (check_idx == trace_len);
        @(posedge clk);
        report_counts();
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // one lfsr bit per cycle for out_ready once reset is released
    always @(posedge clk) begin
        if (reset) begin
            out_ready <= 1'b0;
        end else begin
            lfsr_state = lfsr_next(lfsr_state);
            out_ready <= lfsr_state[0];
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            // load_pending only while a read waits for its data
            check_value("load_pending", load_pending, busy && !out_valid && cur_pend);
            if (out_valid && out_ready) begin
                if (check_idx < trace_len) begin
                    check_value("wb_rd_addr", wb_rd_addr, tr_rd_addr[check_idx]);
                    check_value("wb_rd_write", wb_rd_write, tr_rd_write[check_idx]);
                    check_value("wb_data", wb_data, tr_wb_data[check_idx]);
                end else begin
                    error_count++;
                    $display("writeback at %0t ns with no instruction left in the trace", $time);
                end
                check_idx++;
                busy = 1'b0;
            end
            if (in_valid && in_ready) begin
                busy = 1'b1;
                cur_pend = tr_pend[accept_idx];
                accept_idx++;
            end
        end
    end

    initial begin : watchdog
        wait (trace_loaded);
        repeat (10 + 40 * trace_len) @(posedge clk);
        $display("timeout: %0d of %0d writebacks seen before the cycle limit",
                 check_idx, trace_len);
        report_counts();
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/lsu_pkg.sv
rtl/store_lane_gen.sv
rtl/load_align.sv
rtl/mem_stage.sv
rtl/axi_sram.sv
rtl/lsu_top.sv
bench/lsu_tb.sv

/* bench/lsu_trace.txt */
# op width addr store_data result rd_addr rd_write rd_from_mem wb_data pend (all hex)
# op 0 none, 1 read, 2 write; width 0 b, 1 bu, 2 h, 3 hu, 4 w; pend is the expected load_pending
0 4 00000000 00000000 12345678 1 1 0 12345678 0
0 0 00000000 deadbeef cafef00d 5 0 0 cafef00d 0
0 4 00000000 00000000 0000000f f 1 0 0000000f 0
2 4 00000100 11223344 00000000 0 0 0 00000000 0
2 4 00000104 55667788 00000000 0 0 0 00000000 0
2 4 00000108 99aabbcc 00000000 0 0 0 00000000 0
2 4 0000010c 8090a0b0 00000000 0 0 0 00000000 0
2 4 00000110 f00d1234 00000000 0 0 0 00000000 0
2 0 00000100 000000a1 00000000 0 0 0 00000000 0
2 1 00000101 000000b2 00000000 0 0 0 00000000 0
2 0 00000102 000000c3 00000000 0 0 0 00000000 0
2 1 00000103 000000d4 00000000 0 0 0 00000000 0
1 4 00000100 00000000 0badf00d 3 1 1 d4c3b2a1 1
2 2 00000104 0000e5f6 00000000 0 0 0 00000000 0
1 4 00000104 00000000 0badf00d 4 1 1 5566e5f6 1
2 3 00000105 00007a7b 00000000 0 0 0 00000000 0
1 4 00000104 00000000 0badf00d 6 1 1 557a7bf6 1
2 2 00000106 00008c9d 00000000 0 0 0 00000000 0
1 4 00000104 00000000 0badf00d 8 1 1 8c9d7bf6 1
1 0 00000100 00000000 0badf00d 2 1 1 ffffffa1 1
1 1 00000101 00000000 0badf00d 9 1 1 000000b2 1
1 0 00000102 00000000 0badf00d a 1 1 ffffffc3 1
1 1 00000103 00000000 0badf00d b 1 1 000000d4 1
1 0 00000111 00000000 0badf00d c 1 1 00000012 1
1 0 00000103 00000000 0badf00d d 0 1 ffffffd4 1
1 2 00000104 00000000 0badf00d 1 1 1 00007bf6 1
1 3 00000105 00000000 0badf00d 2 1 1 00009d7b 1
1 2 00000105 00000000 0badf00d 3 1 1 ffff9d7b 1
1 2 00000106 00000000 0badf00d 4 1 1 ffff8c9d 1
1 3 00000106 00000000 0badf00d 5 1 1 00008c9d 1
1 2 00000107 00000000 0badf00d 6 1 1 00000000 1
1 3 00000107 00000000 0badf00d 7 1 1 00000000 1
2 2 00000103 0000ffff 00000000 0 0 0 00000000 0
2 4 00000109 12121212 00000000 0 0 0 00000000 0
1 4 00000108 00000000 0badf00d 8 1 1 99aabbcc 1
1 4 00000100 00000000 0badf00d 9 1 1 d4c3b2a1 1
1 4 0000010a 00000000 0badf00d a 1 1 99aabbcc 1
1 4 0000010d 00000000 0badf00d b 1 1 8090a0b0 1
1 4 0000050c 00000000 0badf00d c 1 1 8090a0b0 1
0 4 00000000 00000000 a5a5a5a5 e 1 0 a5a5a5a5 0
1 4 00000110 00000000 0badf00d 7 1 1 f00d1234 1
2 0 00000113 000000ee 00000000 0 0 0 00000000 0
1 4 00000110 00000000 0badf00d 7 1 1 ee0d1234 1
1 3 00000112 00000000 0badf00d f 1 1 0000ee0d 1
2 1 00000110 0000007f 00000000 0 0 0 00000000 0
1 0 00000110 00000000 0badf00d 1 1 1 0000007f 1
1 4 00000110 00000000 0badf00d 2 1 1 ee0d127f 1
0 3 00000000 00000000 00000000 0 0 0 00000000 0
2 3 00000112 00003344 00000000 0 0 0 00000000 0
1 4 00000110 00000000 0badf00d 3 1 1 3344127f 1
